// File: compile.f
design/platform_pkg.sv
design/debounce.sv
design/bus_ctrl.sv
design/onchip_ram.sv
design/led_pio.sv
design/interval_timer.sv
design/platform.sv
tb/platform_chk.sv
tb/platform_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= platform_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= compile.f
VFLAGS    ?= --binary --assert --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST PASSED" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb/platform_tb.sv
`default_nettype none

module platform_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import platform_pkg::*;

	localparam int N = 20;

	logic     clk, rst, halt, start, ready, irq;
	bus_req_t req;
	word_t    data_rd;
	led_t     leds;

	int          errors = 0;
	logic [31:0] lfsr = 32'he68a;
	realtime     start_time;
	word_t       ref_mem [RAM_WORDS];
	ram_index_t  addrs [64];

	platform platform_inst (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// taps 32 22 2 1
	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	task automatic check(string name, logic [31:0] expected, logic [31:0] actual);
		assert (expected === actual)
		else begin
			$display("[FAIL] %s expected %h actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic bus_xfer(word_addr_t addr, logic write, word_t wdata, output word_t rdata);
		@(negedge clk);
		start = 1'b1;
		req = '{addr: addr, write: write, data_wr: wdata};
		start_time = $realtime;
		@(negedge clk);
		start = 1'b0;
		req = '0;
		while (!ready)
			@(negedge clk);
		rdata = data_rd;
	endtask

	task automatic bus_write(word_addr_t addr, word_t wdata);
		word_t unused;
		bus_xfer(addr, 1'b1, wdata, unused);
		check("write_data_rd_zero", 32'h0, unused);
	endtask

	task automatic bus_read(word_addr_t addr, output word_t rdata);
		bus_xfer(addr, 1'b0, '0, rdata);
	endtask

	function automatic word_addr_t tmr_addr(tmr_reg_t off);
		return {REGION_TIMER, 26'h0, off};
	endfunction

	initial begin
		repeat (4000) @(posedge clk);
		$display("timeout: run did not finish within 4000 cycles");
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		word_t   rd, c1, c2, c3;
		word_t   v;
		realtime t1, t2;
		int      k;
		rst = 1'b1;
		halt = 1'b0;
		start = 1'b0;
		req = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		check("reset_leds", 0, leds);
		check("reset_irq", 0, irq);
		check("reset_ready", 0, ready);
		bus_read(tmr_addr(TMR_STATUS), rd);
		check("reset_status", 0, rd);

		for (int i = 0; i < 64; i++) begin
			addrs[i] = ram_index_t'(rand_bits(10));
			v = rand_bits(32);
			ref_mem[addrs[i]] = v;
			bus_write({REGION_RAM, 18'h0, addrs[i]}, v);
		end
		for (int i = 0; i < 64; i++) begin
			bus_read({REGION_RAM, 18'h0, addrs[i]}, rd);
			check("ram_readback", ref_mem[addrs[i]], rd);
		end

		v = rand_bits(32);
		bus_write({REGION_PIO, 28'h0}, v);
		@(negedge clk);
		check("led_output", v[7:0], leds);
		bus_read({REGION_PIO, 28'h0}, rd);
		check("led_readback", {24'h0, v[7:0]}, rd);

		// unmapped alias of a RAM index, data unlike both the RAM word and leds
		bus_write({2'b11, 18'h0, addrs[0]}, {~ref_mem[addrs[0]][31:8], ~v[7:0]});
		bus_read({2'b11, 18'h0, addrs[0]}, rd);
		check("unmapped_read", 0, rd);
		bus_read({REGION_RAM, 18'h0, addrs[0]}, rd);
		check("unmapped_ram_kept", ref_mem[addrs[0]], rd);
		check("unmapped_leds_kept", v[7:0], leds);

		bus_write(tmr_addr(TMR_LOAD), N);
		bus_write(tmr_addr(TMR_CTRL), 32'h3);
		while (!irq)
			@(negedge clk);
		t1 = $realtime;
		// write edge follows start by half a period, irq seen half a period after its edge
		k = int'((t1 - start_time - 40) / 40);
		check("timer_irq_window", 1, k >= N + 1 && k <= N + 3);
		bus_write(tmr_addr(TMR_STATUS), 32'h1);
		check("timer_irq_cleared", 0, irq);
		while (!irq)
			@(negedge clk);
		t2 = $realtime;
		check("timer_irq_period", N + 1, int'((t2 - t1) / 40));

		bus_write(tmr_addr(TMR_LOAD), 1000);
		bus_write(tmr_addr(TMR_CTRL), 32'h1);
		halt = 1'b1;
		repeat (DEBOUNCE_CYCLES + 8) @(negedge clk);
		bus_read(tmr_addr(TMR_COUNT), c1);
		repeat (10) @(negedge clk);
		bus_read(tmr_addr(TMR_COUNT), c2);
		check("halt_frozen", c1, c2);
		halt = 1'b0;
		repeat (DEBOUNCE_CYCLES + 8) @(negedge clk);
		bus_read(tmr_addr(TMR_COUNT), c3);
		check("halt_resumed", 1, c3 < c1);

		repeat (2) @(negedge clk);
		$display("checks done, errors: %0d, assertion failures: %0d", errors,
			platform_inst.platform_chk_inst.failures);
		if (errors == 0 && platform_inst.platform_chk_inst.failures == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/platform_chk.sv
`default_nettype none

module platform_chk
(
	input wire logic                   clk,
	input wire logic                   rst,
	input wire logic                   accept,
	input wire logic                   ready,
	input wire logic                   ram_sel,
	input wire logic                   pio_sel,
	input wire logic                   tmr_sel,
	input wire platform_pkg::bus_req_t tgt_req,
	input wire logic                   irq
);
	timeunit 1ns;
	timeprecision 1ps;
	import platform_pkg::*;

	logic outstanding;
	logic irq_en_seen;
	int   failures = 0;

	always_ff @(posedge clk) begin
		if (rst)
			outstanding <= 1'b0;
		else if (accept)
			outstanding <= 1'b1;
		else if (ready)
			outstanding <= 1'b0;
	end

	// interrupt enable as last written over the bus
	always_ff @(posedge clk) begin
		if (rst)
			irq_en_seen <= 1'b0;
		else if (tmr_sel && tgt_req.write && tgt_req.addr[1:0] == TMR_CTRL)
			irq_en_seen <= tgt_req.data_wr[TMR_CTRL_IRQ_EN];
	end

	a_ready_one: assert property (@(posedge clk) disable iff (rst) ready |=> !ready)
		else begin
			$error("ready held for more than one cycle");
			failures++;
		end

	a_ram_latency: assert property (@(posedge clk) disable iff (rst)
		ram_sel |=> !ready ##1 ready)
		else begin
			$error("RAM request not answered after two cycles");
			failures++;
		end

	a_other_latency: assert property (@(posedge clk) disable iff (rst)
		accept && !ram_sel |=> ready)
		else begin
			$error("non-RAM request not answered after one cycle");
			failures++;
		end

	a_no_orphan: assert property (@(posedge clk) disable iff (rst) ready |-> outstanding)
		else begin
			$error("ready without an outstanding request");
			failures++;
		end

	a_one_sel: assert property (@(posedge clk) disable iff (rst)
		$onehot0({ram_sel, pio_sel, tmr_sel}))
		else begin
			$error("more than one select strobe high");
			failures++;
		end

	a_irq_masked: assert property (@(posedge clk) disable iff (rst) !irq_en_seen |-> !irq)
		else begin
			$error("irq high with interrupt enable clear");
			failures++;
		end

endmodule

// hooked at the top level to see the target bus and irq
bind platform platform_chk platform_chk_inst
(
	.clk(clk),
	.rst(rst),
	.accept(ctrl.accept),
	.ready(ready),
	.ram_sel(ram_sel),
	.pio_sel(pio_sel),
	.tmr_sel(tmr_sel),
	.tgt_req(tgt_req),
	.irq(irq)
);

`default_nettype wire

// File: design/platform.sv
`default_nettype none

module platform
(
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   halt,
	input  logic                   start,
	input  platform_pkg::bus_req_t req,
	output logic                   ready,
	output platform_pkg::word_t    data_rd,
	output logic                   irq,
	output platform_pkg::led_t     leds
);
	import platform_pkg::*;

	bus_req_t tgt_req;
	word_t    ram_rdata, pio_rdata, tmr_rdata;
	logic     halt_clean, ram_sel, pio_sel, tmr_sel;

	debounce halt_debounce
	(
		.clk(clk),
		.rst(rst),
		.dirty(halt),
		.clean(halt_clean)
	);

	bus_ctrl ctrl
	(
		.clk(clk),
		.rst(rst),
		.start(start),
		.req(req),
		.ready(ready),
		.data_rd(data_rd),
		.tgt_req(tgt_req),
		.ram_sel(ram_sel),
		.pio_sel(pio_sel),
		.tmr_sel(tmr_sel),
		.ram_rdata(ram_rdata),
		.pio_rdata(pio_rdata),
		.tmr_rdata(tmr_rdata)
	);

	onchip_ram ram
	(
		.clk(clk),
		.rst(rst),
		.sel(ram_sel),
		.req(tgt_req),
		.rdata(ram_rdata)
	);

	led_pio pio
	(
		.clk(clk),
		.rst(rst),
		.sel(pio_sel),
		.req(tgt_req),
		.rdata(pio_rdata),
		.leds(leds)
	);

	// debug halt freezes the count
	interval_timer timer
	(
		.clk(clk),
		.rst(rst),
		.halt(halt_clean),
		.sel(tmr_sel),
		.req(tgt_req),
		.rdata(tmr_rdata),
		.irq(irq)
	);

endmodule

`default_nettype wire

// File: design/interval_timer.sv
`default_nettype none

module interval_timer
(
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   halt,
	input  logic                   sel,
	input  platform_pkg::bus_req_t req,
	output platform_pkg::word_t    rdata,
	output logic                   irq
);
	import platform_pkg::*;

	word_t    load_q, count_q;
	logic     enable, irq_en, pending;
	logic     wr, counting, wrap;
	tmr_reg_t offset;

	assign offset   = tmr_reg_of(req.addr);
	assign wr       = sel && req.write;
	assign counting = enable && !halt;
	assign wrap     = counting && count_q == '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			load_q  <= '0;
			count_q <= '0;
			enable  <= 1'b0;
			irq_en  <= 1'b0;
			pending <= 1'b0;
		end else begin
			if (counting)
				count_q <= wrap ? load_q : count_q - 1'b1;

			// a wrap in the same cycle wins over the clear
			if (wr && offset == TMR_STATUS && req.data_wr[TMR_STATUS_PENDING])
				pending <= 1'b0;
			if (wrap)
				pending <= 1'b1;

			if (wr && offset == TMR_LOAD)
				load_q <= req.data_wr;

			if (wr && offset == TMR_CTRL) begin
				enable <= req.data_wr[TMR_CTRL_ENABLE];
				irq_en <= req.data_wr[TMR_CTRL_IRQ_EN];

				// enabling restarts from the load value
				if (req.data_wr[TMR_CTRL_ENABLE])
					count_q <= load_q;
			end
		end
	end

	assign irq = pending && irq_en;

	always_comb begin
		rdata = '0;

		case (offset)
			TMR_LOAD:
				rdata = load_q;

			TMR_CTRL: begin
				rdata[TMR_CTRL_ENABLE] = enable;
				rdata[TMR_CTRL_IRQ_EN] = irq_en;
			end

			TMR_COUNT:
				rdata = count_q;

			TMR_STATUS:
				rdata[TMR_STATUS_PENDING] = pending;

			default:
				rdata = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: design/led_pio.sv
`default_nettype none

module led_pio
(
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   sel,
	input  platform_pkg::bus_req_t req,
	output platform_pkg::word_t    rdata,
	output platform_pkg::led_t     leds
);
	import platform_pkg::*;

	// every offset in the region maps to the same register
	always_ff @(posedge clk) begin
		if (rst)
			leds <= '0;
		else if (sel && req.write)
			leds <= req.data_wr[$bits(led_t)-1:0];
	end

	assign rdata = word_t'(leds);

endmodule

`default_nettype wire

// File: design/onchip_ram.sv
`default_nettype none

module onchip_ram
(
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   sel,
	input  platform_pkg::bus_req_t req,
	output platform_pkg::word_t    rdata
);
	import platform_pkg::*;

	word_t      mem [RAM_WORDS];
	ram_index_t index;

	// upper address bits already decoded by region
	assign index = req.addr[$bits(ram_index_t)-1:0];

	always_ff @(posedge clk) begin
		if (sel && req.write)
			mem[index] <= req.data_wr;
	end

	// read word holds until the next select
	always_ff @(posedge clk) begin
		if (rst)
			rdata <= '0;
		else if (sel && !req.write)
			rdata <= mem[index];
	end

endmodule

`default_nettype wire

// File: design/bus_ctrl.sv
`default_nettype none

module bus_ctrl
(
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   start,
	input  platform_pkg::bus_req_t req,
	output logic                   ready,
	output platform_pkg::word_t    data_rd,
	output platform_pkg::bus_req_t tgt_req,
	output logic                   ram_sel,
	output logic                   pio_sel,
	output logic                   tmr_sel,
	input  platform_pkg::word_t    ram_rdata,
	input  platform_pkg::word_t    pio_rdata,
	input  platform_pkg::word_t    tmr_rdata
);
	import platform_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		RAM_WAIT,
		RESPOND
	} state_t;

	state_t   state, state_next;
	bus_req_t req_q;
	region_t  region_in, region_q;
	logic     accept;

	// requests only taken while idle
	assign accept    = start && state == IDLE;
	assign region_in = region_of(req.addr);
	assign region_q  = region_of(req_q.addr);

	// the new request on its accept cycle, the held one after
	assign tgt_req = accept ? req : req_q;

	assign ram_sel = accept && region_in == REGION_RAM;
	assign pio_sel = accept && region_in == REGION_PIO;
	assign tmr_sel = accept && region_in == REGION_TIMER;

	assign ready = state == RESPOND;

	always_comb begin
		state_next = state;

		case (state)
			IDLE: begin
				if (start)
					state_next = region_in == REGION_RAM ? RAM_WAIT : RESPOND;
			end

			// one extra cycle for the registered RAM read
			RAM_WAIT:
				state_next = RESPOND;

			RESPOND:
				state_next = IDLE;

			default:
				state_next = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			state <= IDLE;
		else
			state <= state_next;
	end

	always_ff @(posedge clk) begin
		if (accept)
			req_q <= req;
	end

	// writes and unmapped reads answer zero
	always_comb begin
		data_rd = '0;

		if (ready && !req_q.write) begin
			case (region_q)
				REGION_RAM:
					data_rd = ram_rdata;

				REGION_PIO:
					data_rd = pio_rdata;

				REGION_TIMER:
					data_rd = tmr_rdata;

				default:
					data_rd = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/debounce.sv
`default_nettype none

module debounce
(
	input  logic clk,
	input  logic rst,
	input  logic dirty,
	output logic clean
);
	import platform_pkg::*;

	logic [1:0] sync_q;
	db_count_t  count;
	logic       synced;

	assign synced = sync_q[1];

	always_ff @(posedge clk) begin
		if (rst) begin
			sync_q <= '0;
			count  <= '0;
			clean  <= 1'b0;
		end else begin
			sync_q <= {sync_q[0], dirty};

			// any return to the old level restarts the count
			if (synced == clean) begin
				count <= '0;
			end else if (count == DEBOUNCE_LAST) begin
				count <= '0;
				clean <= synced;
			end else begin
				count <= count + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: design/platform_pkg.sv
`default_nettype none

package platform_pkg;

	typedef logic [31:0] word_t;
	typedef logic [29:0] word_addr_t;
	typedef logic [9:0]  ram_index_t;
	typedef logic [7:0]  led_t;
	typedef logic [1:0]  region_t;
	typedef logic [1:0]  tmr_reg_t;

	// travels with start
	typedef struct packed {
		word_addr_t addr;
		logic       write;
		word_t      data_wr;
	} bus_req_t;

	localparam int RAM_WORDS = 1024;

	// address bits 29:28, code 3 is unmapped
	localparam region_t REGION_RAM   = 2'd0;
	localparam region_t REGION_PIO   = 2'd1;
	localparam region_t REGION_TIMER = 2'd2;

	// timer registers, address bits 1:0
	localparam tmr_reg_t TMR_LOAD   = 2'd0;
	localparam tmr_reg_t TMR_CTRL   = 2'd1;
	localparam tmr_reg_t TMR_COUNT  = 2'd2;
	localparam tmr_reg_t TMR_STATUS = 2'd3;

	localparam int TMR_CTRL_ENABLE    = 0;
	localparam int TMR_CTRL_IRQ_EN    = 1;
	localparam int TMR_STATUS_PENDING = 0;

	localparam int DEBOUNCE_CYCLES = 16;
	typedef logic [$clog2(DEBOUNCE_CYCLES)-1:0] db_count_t;
	localparam db_count_t DEBOUNCE_LAST = db_count_t'(DEBOUNCE_CYCLES - 1);

	function automatic region_t region_of(word_addr_t addr);
		return addr[29:28];
	endfunction

	function automatic tmr_reg_t tmr_reg_of(word_addr_t addr);
		return addr[1:0];
	endfunction

endpackage

`default_nettype wire
